//--- common/opq_pkg.sv
// Shared types and constants for the vector lane operand queue.
// Import this package inside a module body and use scoped names in port lists.

package opq_pkg;

  // Queue geometry
  localparam int unsigned BufferDepth = 4;
  localparam int unsigned NrConsumers = 2;
  localparam int unsigned CreditWidth = $clog2(BufferDepth + 1);

  // Byte offset into one data word
  localparam int unsigned SelWidth = 3;

  // IEEE exponent biases
  localparam int unsigned Fp16Bias = 15;
  localparam int unsigned Fp32Bias = 127;
  localparam int unsigned Fp64Bias = 1023;

  typedef logic [63:0] elen_t;
  typedef logic [15:0] vlen_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  typedef enum logic [2:0] {
    OpqConvNone    = 3'd0,
    OpqConvSExt2   = 3'd1,
    OpqConvSExt4   = 3'd2,
    OpqConvSExt8   = 3'd3,
    OpqConvZExt2   = 3'd4,
    OpqConvZExt4   = 3'd5,
    OpqConvZExt8   = 3'd6,
    OpqConvWideFp2 = 3'd7
  } conv_e;

  typedef struct packed {
    conv_e conv;
    eew_e  eew;
    vlen_t vl;
  } opq_cmd_t;

  typedef struct packed {
    logic        s;
    logic [4:0]  e;
    logic [9:0]  m;
  } fp16_t;

  typedef struct packed {
    logic        s;
    logic [7:0]  e;
    logic [22:0] m;
  } fp32_t;

  typedef struct packed {
    logic        s;
    logic [10:0] e;
    logic [51:0] m;
  } fp64_t;

  // One word seen as raw bits or as packed fp fields
  typedef union packed {
    elen_t        raw;
    fp16_t [3:0]  h;
    fp32_t [1:0]  s;
    fp64_t        d;
  } elen_u;

  // log2 of the widening ratio, zero for pass-through and illegal combinations
  function automatic logic [1:0] conv_ratio_log(opq_cmd_t cmd);
    logic [1:0] r;
    unique case (cmd.conv)
      OpqConvSExt2, OpqConvZExt2, OpqConvWideFp2: r = 2'd1;
      OpqConvSExt4, OpqConvZExt4:                 r = 2'd2;
      OpqConvSExt8, OpqConvZExt8:                 r = 2'd3;
      default:                                    r = 2'd0;
    endcase
    // Widened element must still fit in 64 bits
    if (int'(cmd.eew) + int'(r) > 3) r = 2'd0;
    // Only fp16 and fp32 sources can be widened
    if (cmd.conv == OpqConvWideFp2 && cmd.eew == EW8) r = 2'd0;
    return r;
  endfunction

endpackage

//--- operand_buffer/opq_fifo.sv
// Register FIFO without fall-through, for commands and for operand words.
// Data appears at data_o in the cycle after the push; pop_i drops the head.

`timescale 1ns/10ps

module opq_fifo #(
  parameter int unsigned Depth = 4,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  dtype                mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  ) else $error("push into a full FIFO");

  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  ) else $error("pop from an empty FIFO");

endmodule

//--- operand_buffer/operand_buffer.sv
// Operand buffer between the register file and the conversion stage.
// Credits are taken on operand_issued_i and returned when a word is popped,
// so a delivered word always finds a free slot.

`timescale 1ns/10ps

module operand_buffer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  opq_pkg::elen_t operand_i,
  input  logic           operand_valid_i,
  input  logic           operand_issued_i,
  input  logic           pop_i,
  output opq_pkg::elen_t word_o,
  output logic           word_valid_o,
  output logic           ready_o
);

  import opq_pkg::*;

  logic                   empty;
  logic [CreditWidth-1:0] credit_d, credit_q;

  opq_fifo #(
    .Depth(BufferDepth),
    .dtype(elen_t)
  ) i_word_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (operand_valid_i),
    .data_i (operand_i),
    .pop_i  (pop_i),
    .data_o (word_o),
    .empty_o(empty),
    .full_o ()
  );

  assign word_valid_o = !empty;

  // Outstanding credits, both issued-but-not-arrived and buffered words
  always_comb begin
    credit_d = credit_q;
    if (operand_issued_i) credit_d = credit_d + 1'b1;
    if (pop_i) credit_d = credit_d - 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= '0;
    end else begin
      credit_q <= credit_d;
    end
  end

  assign ready_o = (credit_q < CreditWidth'(BufferDepth));

  a_issue_when_ready : assert property (
    @(posedge clk_i) disable iff (!rst_ni) operand_issued_i |-> ready_o
  ) else $error("operand issued while the buffer has no credit");

  a_credit_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_q <= CreditWidth'(BufferDepth)
  ) else $error("credit count exceeds the buffer depth");

endmodule

//--- hw/opq_widen.sv
// Combinational widening of the buffer head word for the current command.
// Starts at byte select_i; integer extension by 2, 4 or 8 and fp16/fp32 widening.
// Illegal conversion and width pairs leave the word untouched.

`timescale 1ns/10ps

module opq_widen (
  input  opq_pkg::elen_t                word_i,
  input  opq_pkg::opq_cmd_t             cmd_i,
  input  logic [opq_pkg::SelWidth-1:0]  select_i,
  output opq_pkg::elen_t                word_o
);

  import opq_pkg::*;

  elen_u       src_u;
  logic [1:0]  ratio_log;
  fp32_t [1:0] wide_s;
  fp64_t       wide_d;

  // Extend each source element of width 8 << eew to width (8 << eew) << r_log
  function automatic elen_t extend(elen_t src, eew_e eew, logic [1:0] r_log, logic sgn);
    elen_t       res;
    int unsigned ew_sh;
    int unsigned ow_sh;
    int unsigned k;
    int unsigned off;
    ew_sh = 3 + int'(eew);
    ow_sh = ew_sh + int'(r_log);
    res   = '0;
    for (int unsigned b = 0; b < 64; b++) begin
      k   = b >> ow_sh;
      off = b & ((1 << ow_sh) - 1);
      if (off < (1 << ew_sh)) begin
        res[b] = src[(k << ew_sh) + off];
      end else begin
        res[b] = sgn & src[(k << ew_sh) + (1 << ew_sh) - 1];
      end
    end
    return res;
  endfunction

  assign ratio_log = conv_ratio_log(cmd_i);

  // Source bits start at the selected byte
  assign src_u.raw = word_i >> {select_i, 3'b000};

  // fp16 to fp32, two lanes
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      wide_s[i].s = src_u.h[i].s;
      wide_s[i].e = {3'b000, src_u.h[i].e} + 8'(Fp32Bias - Fp16Bias);
      wide_s[i].m = {src_u.h[i].m, 13'b0};
    end
  end

  // fp32 to fp64, single lane
  always_comb begin
    wide_d.s = src_u.s[0].s;
    wide_d.e = {3'b000, src_u.s[0].e} + 11'(Fp64Bias - Fp32Bias);
    wide_d.m = {src_u.s[0].m, 29'b0};
  end

  always_comb begin
    word_o = word_i;
    if (ratio_log != 2'd0) begin
      unique case (cmd_i.conv)
        OpqConvSExt2, OpqConvSExt4, OpqConvSExt8: begin
          word_o = extend(src_u.raw, cmd_i.eew, ratio_log, 1'b1);
        end
        OpqConvZExt2, OpqConvZExt4, OpqConvZExt8: begin
          word_o = extend(src_u.raw, cmd_i.eew, ratio_log, 1'b0);
        end
        OpqConvWideFp2: begin
          if (cmd_i.eew == EW16) begin
            word_o = wide_s;
          end else begin
            word_o = wide_d;
          end
        end
        default: begin
          word_o = word_i;
        end
      endcase
    end
  end

endmodule

//--- hw/opq_sequencer.sv
// Output control of the operand queue.
// Counts elements against vl, steps the byte select through the head word
// and pops the word and command FIFOs on each consumer transfer.

`timescale 1ns/10ps

module opq_sequencer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  opq_pkg::opq_cmd_t                   cmd_i,
  input  logic                                cmd_valid_i,
  input  logic                                word_valid_i,
  input  logic [opq_pkg::NrConsumers-1:0]     ready_i,
  output logic [opq_pkg::SelWidth-1:0]        select_o,
  output logic                                word_pop_o,
  output logic                                cmd_pop_o,
  output logic                                operand_valid_o
);

  import opq_pkg::*;

  logic [1:0]             ratio_log;
  logic [1:0]             elem_log;
  logic                   xfer;
  logic [SelWidth-1:0]    select_d, select_q;
  vlen_t                  count_d, count_q;
  logic [$bits(vlen_t):0] count_next;

  assign ratio_log = conv_ratio_log(cmd_i);

  // Elements carried by one output word are 8 / (eew bytes * R)
  assign elem_log = 2'd3 - cmd_i.eew - ratio_log;

  assign operand_valid_o = word_valid_i && cmd_valid_i;
  assign xfer            = operand_valid_o && |ready_i;
  assign select_o        = select_q;

  assign count_next = {1'b0, count_q} + ((($bits(vlen_t) + 1)'(1)) << elem_log);

  always_comb begin
    select_d   = select_q;
    count_d    = count_q;
    word_pop_o = 1'b0;
    cmd_pop_o  = 1'b0;
    if (xfer) begin
      count_d = count_next[$bits(vlen_t)-1:0];
      if (ratio_log == 2'd0) begin
        word_pop_o = 1'b1;
      end else begin
        // Advance by 8 / R bytes and finish the word when the select wraps
        select_d = select_q + SelWidth'(4'd8 >> ratio_log);
        if (select_d == '0) word_pop_o = 1'b1;
      end
      // End of this command's stream
      if (count_next >= {1'b0, cmd_i.vl}) begin
        word_pop_o = 1'b1;
        cmd_pop_o  = 1'b1;
        select_d   = '0;
        count_d    = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      select_q <= '0;
      count_q  <= '0;
    end else begin
      select_q <= select_d;
      count_q  <= count_d;
    end
  end

  // Words only arrive for commands that are already queued
  a_word_has_cmd : assert property (
    @(posedge clk_i) disable iff (!rst_ni) word_valid_i |-> cmd_valid_i
  ) else $error("operand word buffered without a command");

endmodule

//--- hw/operand_queue.sv
// Top level of the vector lane operand queue.
// Command FIFO, operand buffer, widening stage and output sequencer.

`timescale 1ns/10ps

module operand_queue (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  opq_pkg::opq_cmd_t               cmd_i,
  input  logic                            cmd_valid_i,
  input  logic                            operand_issued_i,
  input  opq_pkg::elen_t                  operand_i,
  input  logic                            operand_valid_i,
  input  logic [opq_pkg::NrConsumers-1:0] ready_i,
  output logic                            operand_ready_o,
  output opq_pkg::elen_t                  operand_o,
  output logic                            operand_valid_o
);

  import opq_pkg::*;

  opq_cmd_t            cmd;
  logic                cmd_empty;
  logic                cmd_pop;
  elen_t               word;
  logic                word_valid;
  logic                word_pop;
  logic [SelWidth-1:0] select;

  opq_fifo #(
    .Depth(BufferDepth),
    .dtype(opq_cmd_t)
  ) i_cmd_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .push_i (cmd_valid_i),
    .data_i (cmd_i),
    .pop_i  (cmd_pop),
    .data_o (cmd),
    .empty_o(cmd_empty),
    .full_o ()
  );

  operand_buffer i_operand_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_issued_i(operand_issued_i),
    .pop_i           (word_pop),
    .word_o          (word),
    .word_valid_o    (word_valid),
    .ready_o         (operand_ready_o)
  );

  opq_widen i_widen (
    .word_i  (word),
    .cmd_i   (cmd),
    .select_i(select),
    .word_o  (operand_o)
  );

  opq_sequencer i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .cmd_valid_i    (!cmd_empty),
    .word_valid_i   (word_valid),
    .ready_i        (ready_i),
    .select_o       (select),
    .word_pop_o     (word_pop),
    .cmd_pop_o      (cmd_pop),
    .operand_valid_o(operand_valid_o)
  );

endmodule

//--- testbench/tb_clock.sv
// Free-running clock for the operand queue testbench.
// Instantiate once and connect clk_o to the DUT clock.

`timescale 1ns/10ps

module tb_clock #(
  parameter int unsigned HalfPeriod = 50
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

endmodule

//--- testbench/tb_operand_queue.sv
// Randomized testbench for the operand queue.
// Pushes random commands, feeds words through the credit interface and checks
// every output word and the ready flag against a model of the widening rules.

`timescale 1ns/10ps

module tb_operand_queue;

  import opq_pkg::*;

  localparam int unsigned NumCmds   = 60;
  localparam int unsigned MaxCycles = 20000;

  logic                   clk;
  logic                   rst_n;
  opq_cmd_t               cmd;
  logic                   cmd_valid;
  logic                   operand_issued;
  elen_t                  operand;
  logic                   operand_valid;
  logic [NrConsumers-1:0] ready;
  logic                   operand_ready;
  elen_t                  result;
  logic                   result_valid;

  // Expected output stream with the pops each output causes
  elen_t       exp_q[$];
  bit          pop_word_q[$];
  bit          pop_cmd_q[$];
  // Words waiting for a credit and then for their delivery cycle
  elen_t       issue_q[$];
  elen_t       deliver_data_q[$];
  int unsigned deliver_due_q[$];
  int unsigned model_credit;
  int          buffered_words;
  int unsigned cmds_open;
  int unsigned words_checked;
  int unsigned mismatches;
  int unsigned other_errors;

  tb_clock i_clock (
    .clk_o(clk)
  );

  operand_queue dut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .operand_issued_i(operand_issued),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .ready_i         (ready),
    .operand_ready_o (operand_ready),
    .operand_o       (result),
    .operand_valid_o (result_valid)
  );

  function automatic int unsigned ratio_log_of(conv_e conv);
    int unsigned r_log;
    case (conv)
      OpqConvSExt2, OpqConvZExt2, OpqConvWideFp2: r_log = 1;
      OpqConvSExt4, OpqConvZExt4:                 r_log = 2;
      OpqConvSExt8, OpqConvZExt8:                 r_log = 3;
      default:                                    r_log = 0;
    endcase
    return r_log;
  endfunction

  // Each ew-bit lane of src grows to ow bits by sign or by zeros
  function automatic elen_t extend_lanes(elen_t src, int unsigned ew, int unsigned ow, bit sgn);
    elen_t res;
    elen_t lane;
    elen_t ew_mask;
    elen_t ow_mask;
    res     = '0;
    ew_mask = (ew == 64) ? '1 : (64'd1 << ew) - 1;
    ow_mask = (ow == 64) ? '1 : (64'd1 << ow) - 1;
    for (int unsigned k = 0; k < 64 / ow; k++) begin
      lane = (src >> (k * ew)) & ew_mask;
      if (sgn && lane[ew-1]) begin
        lane = lane | ~ew_mask;
      end
      res = res | ((lane & ow_mask) << (k * ow));
    end
    return res;
  endfunction

  // Half to single precision rebiases 15 to 127
  function automatic elen_t widen_half(elen_t src);
    elen_t       res;
    logic [15:0] h;
    logic [7:0]  e8;
    res = '0;
    for (int i = 0; i < 2; i++) begin
      h  = src[16*i +: 16];
      e8 = {3'b000, h[14:10]} + 8'd112;
      res[32*i +: 32] = {h[15], e8, h[9:0], 13'b0};
    end
    return res;
  endfunction

  // Single to double precision rebiases 127 to 1023
  function automatic elen_t widen_single(elen_t src);
    logic [10:0] e11;
    e11 = {3'b000, src[30:23]} + 11'd896;
    return {src[31], e11, src[22:0], 29'b0};
  endfunction

  function automatic elen_t expected_output(elen_t w, opq_cmd_t c, int unsigned byte_off);
    elen_t       src;
    elen_t       res;
    int unsigned ew;
    int unsigned r;
    src = w >> (8 * byte_off);
    ew  = 8 << int'(c.eew);
    r   = 1 << ratio_log_of(c.conv);
    case (c.conv)
      OpqConvSExt2, OpqConvSExt4, OpqConvSExt8: res = extend_lanes(src, ew, ew * r, 1'b1);
      OpqConvZExt2, OpqConvZExt4, OpqConvZExt8: res = extend_lanes(src, ew, ew * r, 1'b0);
      OpqConvWideFp2: res = (c.eew == EW16) ? widen_half(src) : widen_single(src);
      default:        res = w;
    endcase
    return res;
  endfunction

  // Input words of one command and every output word they give
  task automatic model_command(input opq_cmd_t c);
    int unsigned r;
    int unsigned per_out;
    int unsigned n_out;
    int unsigned n_in;
    int unsigned k;
    elen_t       w;
    r       = 1 << ratio_log_of(c.conv);
    per_out = 8 / ((1 << int'(c.eew)) * r);
    n_out   = (int'(c.vl) + per_out - 1) / per_out;
    n_in    = (n_out + r - 1) / r;
    k       = 0;
    for (int unsigned i = 0; i < n_in; i++) begin
      w = {$urandom(), $urandom()};
      issue_q.push_back(w);
      for (int unsigned j = 0; j < r; j++) begin
        if (k < n_out) begin
          exp_q.push_back(expected_output(w, c, j * (8 / r)));
          pop_word_q.push_back(j == r - 1 || k == n_out - 1);
          pop_cmd_q.push_back(k == n_out - 1);
          k++;
        end
      end
    end
  endtask

  task automatic push_command();
    opq_cmd_t    c;
    int unsigned r_log;
    c.conv = conv_e'($urandom_range(0, 7));
    r_log  = ratio_log_of(c.conv);
    if (c.conv == OpqConvWideFp2) begin
      c.eew = eew_e'($urandom_range(1, 2));
    end else begin
      c.eew = eew_e'($urandom_range(0, 3 - r_log));
    end
    c.vl = vlen_t'($urandom_range(1, 40));
    cmd       <= c;
    cmd_valid <= 1'b1;
    cmds_open++;
    model_command(c);
  endtask

  task automatic check_operand(input elen_t got, input elen_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("CHECK FAILED at %0t: output word %0d is %h, expected %h",
               $time, words_checked, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("CHECK FAILED at %0t: operand_ready_o is %b, expected %b with %0d credits",
               $time, got, exp, model_credit);
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("CHECK FAILED at %0t: operand_valid_o is %b, expected %b with %0d words held",
               $time, got, exp, buffered_words);
    end
  endtask

  task automatic check_idle(input logic valid, input logic rdy);
    if (valid !== 1'b0 || rdy !== 1'b1) begin
      mismatches++;
      $display("CHECK FAILED at %0t: queue not idle, valid %b ready %b",
               $time, valid, rdy);
    end
  endtask

  // Inputs only move at rising edges so mid-cycle values show the next edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_ready(operand_ready, model_credit < BufferDepth);
      check_valid(result_valid, buffered_words > 0);
      if (result_valid && exp_q.size() == 0) begin
        other_errors++;
        $display("ERROR at %0t: output valid with no word expected", $time);
      end else if (result_valid && |ready) begin
        check_operand(result, exp_q.pop_front());
        if (pop_word_q.pop_front()) begin
          model_credit--;
          buffered_words--;
        end
        if (pop_cmd_q.pop_front()) cmds_open--;
        words_checked++;
      end
      if (operand_issued) model_credit++;
      if (operand_valid) buffered_words++;
    end
  end

  initial begin
    int unsigned cycle;
    int unsigned due;
    int unsigned last_due;
    int unsigned cmds_pushed;
    bit          done;
    void'($urandom(82004));
    rst_n          = 1'b0;
    cmd            = '0;
    cmd_valid      = 1'b0;
    operand_issued = 1'b0;
    operand        = '0;
    operand_valid  = 1'b0;
    ready          = '0;
    model_credit   = 0;
    buffered_words = 0;
    cmds_open      = 0;
    words_checked  = 0;
    mismatches     = 0;
    other_errors   = 0;
    cycle          = 0;
    last_due       = 0;
    cmds_pushed    = 0;
    done           = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    while (!done && cycle < MaxCycles) begin
      @(posedge clk);
      cycle++;
      cmd_valid      <= 1'b0;
      operand_issued <= 1'b0;
      operand_valid  <= 1'b0;
      ready          <= NrConsumers'($urandom_range(0, (1 << NrConsumers) - 1));
      if (cmds_pushed < NumCmds && cmds_open < BufferDepth && $urandom_range(0, 3) != 0) begin
        push_command();
        cmds_pushed++;
      end
      if (deliver_due_q.size() > 0 && deliver_due_q[0] <= cycle) begin
        void'(deliver_due_q.pop_front());
        operand       <= deliver_data_q.pop_front();
        operand_valid <= 1'b1;
      end
      // Credit count after this edge is already in the model
      if (issue_q.size() > 0 && model_credit < BufferDepth && $urandom_range(0, 3) != 0) begin
        operand_issued <= 1'b1;
        due = cycle + $urandom_range(1, 3);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        deliver_due_q.push_back(due);
        deliver_data_q.push_back(issue_q.pop_front());
      end
      done = (cmds_pushed == NumCmds) && (issue_q.size() == 0) &&
             (deliver_due_q.size() == 0) && (exp_q.size() == 0);
    end

    if (!done) begin
      other_errors++;
      $display("Timeout after %0d cycles with %0d output words still expected",
               cycle, exp_q.size());
    end else begin
      @(negedge clk);
      check_idle(result_valid, operand_ready);
    end

    $display("Checked %0d words over %0d commands: %0d mismatches, %0d other errors",
             words_checked, cmds_pushed, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
common/opq_pkg.sv
operand_buffer/opq_fifo.sv
operand_buffer/operand_buffer.sv
hw/opq_widen.sv
hw/opq_sequencer.sv
hw/operand_queue.sv
testbench/tb_clock.sv
testbench/tb_operand_queue.sv
